//--- verilog/agu_pkg.sv
package agu_pkg;

  // address geometry
  localparam int VADDR_W = 44;
  localparam int PADDR_W = 44;
  localparam int PAGE_BITS = 13;
  localparam int ROW_BITS = 7;
  localparam int ROW_IDX_W = PAGE_BITS - ROW_BITS;
  localparam int BANK_COUNT = 32;
  localparam int TLB_ENTRIES = 8;

  // bit positions inside fault_code_t
  localparam int FAULT_NA = 0;
  localparam int FAULT_PRIV = 1;

  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [PADDR_W-1:0] paddr_t;
  typedef logic [VADDR_W-PAGE_BITS-1:0] vpn_t;
  typedef logic [PADDR_W-PAGE_BITS-1:0] ppn_t;
  typedef logic [ROW_IDX_W-1:0] row_idx_t;
  typedef logic [BANK_COUNT-1:0] bank_mask_t;
  typedef logic [$clog2(BANK_COUNT)-1:0] bank_idx_t;
  typedef logic [4:0] size_code_t;
  typedef logic [8:0] reg_tag_t;
  typedef logic [1:0] fault_code_t;

  // byte count of an access, 20 bytes at most
  function automatic logic [4:0] size_bytes(size_code_t sz);
    logic [4:0] n;
    case (sz)
      5'd16: n = 5'd1;
      5'd17: n = 5'd2;
      5'd18: n = 5'd4;
      5'd19: n = 5'd8;
      // extended precision
      5'd3: n = 5'd10;
      // 128 bit, unaligned and aligned forms
      5'd0, 5'd1, 5'd2: n = 5'd16;
      5'd12, 5'd13, 5'd14: n = 5'd16;
      // single precision group
      5'd4, 5'd5, 5'd6: n = 5'd4;
      // double precision group
      5'd8, 5'd9, 5'd10: n = 5'd8;
      // fill/spill
      5'd15: n = 5'd20;
      default: n = 5'd8;
    endcase
    return n;
  endfunction

endpackage

//--- verilog/tlb_lookup_if.sv
`timescale 1ns/1ps

interface tlb_lookup_if;

  // request side
  agu_pkg::vpn_t vpn;
  logic valid;

  // result for vpn
  logic hit;
  agu_pkg::ppn_t ppn;
  logic sys;
  logic na;

  // result for vpn + 1
  logic hit_next;
  agu_pkg::ppn_t ppn_next;
  logic sys_next;
  logic na_next;

  modport requester (
    output vpn, valid,
    input hit, ppn, sys, na,
    input hit_next, ppn_next, sys_next, na_next
  );

  modport translator (
    input vpn, valid,
    output hit, ppn, sys, na,
    output hit_next, ppn_next, sys_next, na_next
  );

endinterface

//--- verilog/dtlb.sv
`timescale 1ns/1ps

module dtlb (
  input logic clk,
  input logic rst,
  tlb_lookup_if.translator lookup,
  input logic wen,
  input agu_pkg::vpn_t wr_vpn,
  input agu_pkg::ppn_t wr_ppn,
  input logic wr_sys,
  input logic wr_na,
  input logic flush
);

  logic [agu_pkg::TLB_ENTRIES-1:0] valid_q;
  agu_pkg::vpn_t tag_q [agu_pkg::TLB_ENTRIES];
  agu_pkg::ppn_t ppn_q [agu_pkg::TLB_ENTRIES];
  logic [agu_pkg::TLB_ENTRIES-1:0] sys_q;
  logic [agu_pkg::TLB_ENTRIES-1:0] na_q;

  logic [$clog2(agu_pkg::TLB_ENTRIES)-1:0] rr_ptr;
  logic [$clog2(agu_pkg::TLB_ENTRIES)-1:0] wr_way;
  logic [agu_pkg::TLB_ENTRIES-1:0] match;
  logic [agu_pkg::TLB_ENTRIES-1:0] match_next;
  logic [agu_pkg::TLB_ENTRIES-1:0] wr_match;
  agu_pkg::vpn_t vpn_next;

  assign vpn_next = lookup.vpn + agu_pkg::vpn_t'(1);

  // both pages compared against every entry in parallel
  always_comb begin
    lookup.ppn = '0;
    lookup.sys = 1'b0;
    lookup.na = 1'b0;
    lookup.ppn_next = '0;
    lookup.sys_next = 1'b0;
    lookup.na_next = 1'b0;
    for (int i = 0; i < agu_pkg::TLB_ENTRIES; i++) begin
      match[i] = valid_q[i] && (tag_q[i] == lookup.vpn);
      match_next[i] = valid_q[i] && (tag_q[i] == vpn_next);
      if (match[i]) begin
        lookup.ppn = lookup.ppn | ppn_q[i];
        lookup.sys = lookup.sys | sys_q[i];
        lookup.na = lookup.na | na_q[i];
      end
      if (match_next[i]) begin
        lookup.ppn_next = lookup.ppn_next | ppn_q[i];
        lookup.sys_next = lookup.sys_next | sys_q[i];
        lookup.na_next = lookup.na_next | na_q[i];
      end
    end
    lookup.hit = lookup.valid && (|match);
    lookup.hit_next = lookup.valid && (|match_next);
  end

  // refill hits an existing page or takes the round-robin way
  always_comb begin
    wr_way = rr_ptr;
    for (int i = 0; i < agu_pkg::TLB_ENTRIES; i++) begin
      wr_match[i] = valid_q[i] && (tag_q[i] == wr_vpn);
      if (wr_match[i]) begin
        wr_way = i[$clog2(agu_pkg::TLB_ENTRIES)-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      rr_ptr <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else if (wen) begin
      valid_q[wr_way] <= 1'b1;
      if (!(|wr_match)) begin
        rr_ptr <= rr_ptr + 1'b1;
      end
    end
  end

  // entry payload, qualified by valid_q
  always_ff @(posedge clk) begin
    if (wen && !flush) begin
      tag_q[wr_way] <= wr_vpn;
      ppn_q[wr_way] <= wr_ppn;
      sys_q[wr_way] <= wr_sys;
      na_q[wr_way] <= wr_na;
    end
  end

  // refill overwrite keeps tags unique
  a_unique_match: assert property (@(posedge clk) disable iff (rst)
    $onehot0(match) && $onehot0(match_next) && $onehot0(wr_match));

endmodule

//--- verilog/bank_mask.sv
`timescale 1ns/1ps

module bank_mask (
  input logic [agu_pkg::ROW_BITS-1:0] addr_low,
  input agu_pkg::size_code_t sz,
  output agu_pkg::bank_mask_t banks,
  output logic split
);

  logic [4:0] nbytes;
  // one extra bit shows a run past the row end
  logic [agu_pkg::ROW_BITS:0] last_byte;
  agu_pkg::bank_idx_t first_bank;
  logic [agu_pkg::ROW_BITS-2:0] last_bank;
  logic [agu_pkg::ROW_BITS-2:0] span;
  agu_pkg::bank_idx_t offset;

  assign nbytes = agu_pkg::size_bytes(sz);

  always_comb begin
    last_byte = {1'b0, addr_low} + (agu_pkg::ROW_BITS + 1)'(nbytes)
              - (agu_pkg::ROW_BITS + 1)'(1);
  end

  // 4 byte banks, so drop the low two bits
  assign first_bank = addr_low[agu_pkg::ROW_BITS-1:2];
  assign last_bank = last_byte[agu_pkg::ROW_BITS:2];

  // banks touched past the first one
  assign span = last_bank - {1'b0, first_bank};

  assign split = last_byte[agu_pkg::ROW_BITS];

  // distance from first bank wraps modulo 32
  always_comb begin
    banks = '0;
    offset = '0;
    for (int i = 0; i < agu_pkg::BANK_COUNT; i++) begin
      offset = agu_pkg::bank_idx_t'(i) - first_bank;
      banks[i] = ({1'b0, offset} <= span);
    end
  end

endmodule

//--- verilog/agu_stage.sv
`timescale 1ns/1ps

module agu_stage (
  input logic clk,
  input logic rst,
  input logic in_en,
  input agu_pkg::vaddr_t in_addr,
  input agu_pkg::size_code_t in_sz,
  input logic in_st,
  input agu_pkg::reg_tag_t in_tag,
  input logic except,
  input logic user_mode,
  tlb_lookup_if.requester lookup,
  output logic op_en,
  output agu_pkg::paddr_t op_paddr,
  output agu_pkg::paddr_t op_next_row,
  output agu_pkg::bank_mask_t op_banks,
  output logic op_split,
  output logic op_st,
  output agu_pkg::reg_tag_t op_tag,
  output logic stall,
  output logic tlb_miss,
  output agu_pkg::vpn_t miss_vpn,
  output logic fault,
  output agu_pkg::fault_code_t fault_code
);

  // held operation
  logic held_en;
  agu_pkg::vaddr_t held_addr;
  agu_pkg::size_code_t held_sz;
  logic held_st;
  agu_pkg::reg_tag_t held_tag;

  agu_pkg::row_idx_t row_idx;
  logic [agu_pkg::ROW_IDX_W:0] row_inc;
  logic need_next;
  logic miss_cur;
  logic miss_nxt;
  logic resolved;
  agu_pkg::fault_code_t fault_vec;
  agu_pkg::ppn_t next_ppn;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_en <= 1'b0;
    end else if (except) begin
      held_en <= 1'b0;
    end else if (!stall) begin
      held_en <= in_en;
    end
  end

  always_ff @(posedge clk) begin
    if (in_en && !stall) begin
      held_addr <= in_addr;
      held_sz <= in_sz;
      held_st <= in_st;
      held_tag <= in_tag;
    end
  end

  assign lookup.vpn = held_addr[agu_pkg::VADDR_W-1:agu_pkg::PAGE_BITS];
  assign lookup.valid = held_en;

  bank_mask i_bank_mask (
    .addr_low (held_addr[agu_pkg::ROW_BITS-1:0]),
    .sz (held_sz),
    .banks (op_banks),
    .split (op_split)
  );

  // second page only when a split starts in the last row
  assign row_idx = held_addr[agu_pkg::PAGE_BITS-1:agu_pkg::ROW_BITS];
  assign need_next = op_split && (&row_idx);

  assign miss_cur = held_en && !lookup.hit;
  assign miss_nxt = held_en && need_next && !lookup.hit_next;

  assign tlb_miss = miss_cur || miss_nxt;
  assign stall = tlb_miss;

  // current page reported first
  assign miss_vpn = lookup.hit ? lookup.vpn + agu_pkg::vpn_t'(1) : lookup.vpn;

  always_comb begin
    fault_vec = '0;
    fault_vec[agu_pkg::FAULT_NA] = lookup.na || (need_next && lookup.na_next);
    fault_vec[agu_pkg::FAULT_PRIV] = user_mode &&
                                     (lookup.sys || (need_next && lookup.sys_next));
  end

  assign resolved = held_en && !tlb_miss;
  assign op_en = resolved && !(|fault_vec);
  assign fault = resolved && (|fault_vec);
  assign fault_code = fault_vec;

  // physical address of the first byte
  assign op_paddr = {lookup.ppn, held_addr[agu_pkg::PAGE_BITS-1:0]};

  // row carry out of the page selects the next page
  assign row_inc = {1'b0, row_idx} + (agu_pkg::ROW_IDX_W + 1)'(1);
  assign next_ppn = row_inc[agu_pkg::ROW_IDX_W] ? lookup.ppn_next : lookup.ppn;
  assign op_next_row = {next_ppn, row_inc[agu_pkg::ROW_IDX_W-1:0],
                        {agu_pkg::ROW_BITS{1'b0}}};

  assign op_st = held_st;
  assign op_tag = held_tag;

  a_issue_or_fault: assert property (@(posedge clk) disable iff (rst)
    !(op_en && fault));

  // a stall always belongs to a captured operation
  a_stall_held: assert property (@(posedge clk) disable iff (rst)
    $rose(stall) |-> $past(in_en && !except));

endmodule

//--- verilog/agu_top.sv
`timescale 1ns/1ps

module agu_top (
  input logic clk,
  input logic rst,
  // operation in
  input logic in_en,
  input agu_pkg::vaddr_t in_addr,
  input agu_pkg::size_code_t in_sz,
  input logic in_st,
  input agu_pkg::reg_tag_t in_tag,
  input logic except,
  input logic user_mode,
  // refill and flush
  input logic tlb_wen,
  input agu_pkg::vpn_t tlb_vpn,
  input agu_pkg::ppn_t tlb_ppn,
  input logic tlb_sys,
  input logic tlb_na,
  input logic tlb_flush,
  // issued operation
  output logic op_en,
  output agu_pkg::paddr_t op_paddr,
  output agu_pkg::paddr_t op_next_row,
  output agu_pkg::bank_mask_t op_banks,
  output logic op_split,
  output logic op_st,
  output agu_pkg::reg_tag_t op_tag,
  output logic stall,
  output logic tlb_miss,
  output agu_pkg::vpn_t miss_vpn,
  output logic fault,
  output agu_pkg::fault_code_t fault_code
);

  tlb_lookup_if lookup_bus ();

  agu_stage i_stage (
    .clk (clk),
    .rst (rst),
    .in_en (in_en),
    .in_addr (in_addr),
    .in_sz (in_sz),
    .in_st (in_st),
    .in_tag (in_tag),
    .except (except),
    .user_mode (user_mode),
    .lookup (lookup_bus.requester),
    .op_en (op_en),
    .op_paddr (op_paddr),
    .op_next_row (op_next_row),
    .op_banks (op_banks),
    .op_split (op_split),
    .op_st (op_st),
    .op_tag (op_tag),
    .stall (stall),
    .tlb_miss (tlb_miss),
    .miss_vpn (miss_vpn),
    .fault (fault),
    .fault_code (fault_code)
  );

  dtlb i_dtlb (
    .clk (clk),
    .rst (rst),
    .lookup (lookup_bus.translator),
    .wen (tlb_wen),
    .wr_vpn (tlb_vpn),
    .wr_ppn (tlb_ppn),
    .wr_sys (tlb_sys),
    .wr_na (tlb_na),
    .flush (tlb_flush)
  );

endmodule

//--- bench/agu_tb.sv
`timescale 1ns/1ps

module agu_tb;

  localparam int CLK_NS = 10;
  // about 200 cycles of tests, with a wide margin
  localparam int CYCLE_BUDGET = 2000;
  localparam agu_pkg::vpn_t VPN_BASE = 31'h0001_2340;

  logic clk;
  logic rst;
  logic in_en;
  agu_pkg::vaddr_t in_addr;
  agu_pkg::size_code_t in_sz;
  logic in_st;
  agu_pkg::reg_tag_t in_tag;
  logic except;
  logic user_mode;
  logic tlb_wen;
  agu_pkg::vpn_t tlb_vpn;
  agu_pkg::ppn_t tlb_ppn;
  logic tlb_sys;
  logic tlb_na;
  logic tlb_flush;
  logic op_en;
  agu_pkg::paddr_t op_paddr;
  agu_pkg::paddr_t op_next_row;
  agu_pkg::bank_mask_t op_banks;
  logic op_split;
  logic op_st;
  agu_pkg::reg_tag_t op_tag;
  logic stall;
  logic tlb_miss;
  agu_pkg::vpn_t miss_vpn;
  logic fault;
  agu_pkg::fault_code_t fault_code;

  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  logic [31:0] rng = 32'hf556_4532;

  // page map, entry 8 is never refilled
  agu_pkg::ppn_t ppn_tab [9];
  logic sys_tab [9];
  logic na_tab [9];

  agu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #(CYCLE_BUDGET * CLK_NS);
    $display("watchdog expired after %0d ns, the run did not finish", CYCLE_BUDGET * CLK_NS);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int byte_count(agu_pkg::size_code_t sz);
    case (sz)
      16: return 1;
      17: return 2;
      18: return 4;
      19: return 8;
      3: return 10;
      0, 1, 2, 12, 13, 14: return 16;
      4, 5, 6: return 4;
      8, 9, 10: return 8;
      15: return 20;
      default: return 8;
    endcase
  endfunction

  // every byte marks its own bank, wrapping past bank 31
  function automatic agu_pkg::bank_mask_t span_banks(logic [6:0] off, int n);
    agu_pkg::bank_mask_t m;
    m = '0;
    for (int j = 0; j < n; j++) begin
      m[((int'(off) + j) / 4) % 32] = 1'b1;
    end
    return m;
  endfunction

  function automatic agu_pkg::vaddr_t page_addr(int k, logic [5:0] row, logic [6:0] off);
    return {VPN_BASE + agu_pkg::vpn_t'(k), row, off};
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_op(agu_pkg::vaddr_t addr, agu_pkg::size_code_t sz, logic st,
                          agu_pkg::reg_tag_t tag);
    in_en = 1'b1;
    in_addr = addr;
    in_sz = sz;
    in_st = st;
    in_tag = tag;
  endtask

  task automatic send_op(agu_pkg::vaddr_t addr, agu_pkg::size_code_t sz, logic st,
                         agu_pkg::reg_tag_t tag);
    drive_op(addr, sz, st, tag);
    tick();
    in_en = 1'b0;
  endtask

  task automatic refill(int k);
    tlb_wen = 1'b1;
    tlb_vpn = VPN_BASE + agu_pkg::vpn_t'(k);
    tlb_ppn = ppn_tab[k];
    tlb_sys = sys_tab[k];
    tlb_na = na_tab[k];
    tick();
    tlb_wen = 1'b0;
  endtask

  task automatic wait_resolve(int limit, output int cycles);
    cycles = 0;
    while (!op_en && !fault && cycles < limit) begin
      tick();
      cycles++;
    end
    if (!op_en && !fault) begin
      $display("no issue and no fault within %0d cycles, at %0t ns", limit, $time);
      errors++;
    end
  endtask

  task automatic expect_miss(int k);
    if (!stall || !tlb_miss || miss_vpn != VPN_BASE + agu_pkg::vpn_t'(k)) begin
      $display("Fail %0t ns: stall %b tlb_miss %b miss_vpn %h, expected a miss on %h",
               $time, stall, tlb_miss, miss_vpn, VPN_BASE + agu_pkg::vpn_t'(k));
      errors++;
    end
  endtask

  task automatic expect_idle(string where);
    if (op_en || stall || tlb_miss || fault) begin
      $display("Fail %0t ns: %s, op_en %b stall %b tlb_miss %b fault %b, expected all low",
               $time, where, op_en, stall, tlb_miss, fault);
      errors++;
    end
  endtask

  // expected result of the held operation, from the page map
  task automatic compare_issue(agu_pkg::vaddr_t addr, agu_pkg::size_code_t sz, logic st,
                               agu_pkg::reg_tag_t tag);
    int k;
    int n;
    logic [5:0] row;
    logic [6:0] off;
    logic split_e;
    logic need_nx;
    agu_pkg::fault_code_t fc;
    agu_pkg::paddr_t paddr_e;
    agu_pkg::paddr_t next_e;
    agu_pkg::bank_mask_t banks_e;
    k = int'(addr[43:13] - VPN_BASE);
    row = addr[12:7];
    off = addr[6:0];
    n = byte_count(sz);
    split_e = (int'(off) + n) > 128;
    need_nx = split_e && (row == 6'd63);
    fc = '0;
    fc[agu_pkg::FAULT_NA] = na_tab[k] || (need_nx && na_tab[k + 1]);
    fc[agu_pkg::FAULT_PRIV] = user_mode && (sys_tab[k] || (need_nx && sys_tab[k + 1]));
    paddr_e = {ppn_tab[k], addr[12:0]};
    next_e = (row == 6'd63) ? {ppn_tab[k + 1], 13'd0} : {ppn_tab[k], row + 6'd1, 7'd0};
    banks_e = span_banks(off, n);
    if (fc != '0) begin
      if (!fault || op_en || fault_code != fc) begin
        $display("Fail %0t ns: fault %b op_en %b fault_code %b, expected fault code %b",
                 $time, fault, op_en, fault_code, fc);
        errors++;
      end
    end else begin
      if (!op_en || fault) begin
        $display("Fail %0t ns: op_en %b fault %b, expected an issue", $time, op_en, fault);
        errors++;
      end
      if (op_paddr != paddr_e || op_st != st || op_tag != tag) begin
        $display("Fail %0t ns: paddr %h st %b tag %h, expected %h %b %h",
                 $time, op_paddr, op_st, op_tag, paddr_e, st, tag);
        errors++;
      end
      if (op_banks != banks_e || op_split != split_e) begin
        $display("Fail %0t ns: sz %0d off %h banks %h split %b, expected %h %b",
                 $time, sz, off, op_banks, op_split, banks_e, split_e);
        errors++;
      end
      if (split_e && op_next_row != next_e) begin
        $display("Fail %0t ns: op_next_row %h, expected %h", $time, op_next_row, next_e);
        errors++;
      end
    end
  endtask

  task automatic report_test(string name, int err_before);
    tests++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    expect_idle("after reset");
    send_op(page_addr(0, 6'd4, 7'h10), 5'd18, 1'b0, 9'h001);
    expect_miss(0);
    except = 1'b1;
    tick();
    except = 1'b0;
    expect_idle("after except");
    report_test("reset state", e0);
  endtask

  task automatic miss_and_refill();
    int e0;
    int cycles;
    agu_pkg::vaddr_t a;
    e0 = errors;
    rng = xorshift(rng);
    a = page_addr(0, {1'b0, rng[4:0]}, rng[12:6]);
    send_op(a, 5'd19, 1'b1, 9'h0a5);
    // new inputs must not replace the stalled operation
    repeat (3) begin
      drive_op(page_addr(2, 6'd1, 7'h00), 5'd16, 1'b0, 9'h1ff);
      tick();
      expect_miss(0);
    end
    in_en = 1'b0;
    refill(0);
    wait_resolve(4, cycles);
    if (cycles != 0) begin
      $display("Fail %0t ns: issue came %0d cycles after the refill edge", $time, cycles + 1);
      errors++;
    end
    compare_issue(a, 5'd19, 1'b1, 9'h0a5);
    a = page_addr(0, 6'd20, 7'h44);
    send_op(a, 5'd4, 1'b0, 9'h10c);
    compare_issue(a, 5'd4, 1'b0, 9'h10c);
    report_test("miss and refill", e0);
  endtask

  task automatic bank_spans();
    int e0;
    agu_pkg::vaddr_t a;
    agu_pkg::size_code_t sz;
    logic [6:0] off;
    e0 = errors;
    refill(2);
    for (int i = 0; i < 64; i++) begin
      rng = xorshift(rng);
      sz = agu_pkg::size_code_t'(i % 32);
      off = rng[12:6];
      // 20 bytes from bank 31 wrap around to bank 3
      if (i == 63) begin
        sz = 5'd15;
        off = 7'h7c;
      end
      a = page_addr(2, rng[5:0] % 6'd63, off);
      drive_op(a, sz, i[0], 9'(i));
      tick();
      compare_issue(a, sz, i[0], 9'(i));
    end
    in_en = 1'b0;
    report_test("bank masks", e0);
  endtask

  task automatic page_crossing();
    int e0;
    int cycles;
    agu_pkg::vaddr_t a;
    e0 = errors;
    // 8 bytes at 0x7a of the last row run into page 1
    a = page_addr(0, 6'd63, 7'h7a);
    send_op(a, 5'd19, 1'b0, 9'h033);
    repeat (2) begin
      expect_miss(1);
      tick();
    end
    refill(1);
    wait_resolve(4, cycles);
    compare_issue(a, 5'd19, 1'b0, 9'h033);
    // inner row, page 3 is not mapped yet
    a = page_addr(2, 6'd10, 7'h7e);
    send_op(a, 5'd18, 1'b1, 9'h034);
    compare_issue(a, 5'd18, 1'b1, 9'h034);
    report_test("page crossing", e0);
  endtask

  task automatic permission_faults();
    int e0;
    agu_pkg::vaddr_t a;
    e0 = errors;
    for (int k = 3; k <= 6; k++) begin
      refill(k);
    end
    a = page_addr(3, 6'd0, 7'h00);
    send_op(a, 5'd18, 1'b0, 9'h040);
    compare_issue(a, 5'd18, 1'b0, 9'h040);
    tick();
    if (fault) begin
      $display("Fail %0t ns: fault still high one cycle later", $time);
      errors++;
    end
    user_mode = 1'b1;
    a = page_addr(4, 6'd5, 7'h20);
    send_op(a, 5'd19, 1'b1, 9'h041);
    compare_issue(a, 5'd19, 1'b1, 9'h041);
    user_mode = 1'b0;
    send_op(a, 5'd19, 1'b1, 9'h042);
    compare_issue(a, 5'd19, 1'b1, 9'h042);
    // split from page 5 into the na page 6
    a = page_addr(5, 6'd63, 7'h7c);
    send_op(a, 5'd13, 1'b0, 9'h043);
    compare_issue(a, 5'd13, 1'b0, 9'h043);
    report_test("faults", e0);
  endtask

  task automatic except_and_flush();
    int e0;
    agu_pkg::vaddr_t a;
    e0 = errors;
    send_op(page_addr(7, 6'd2, 7'h08), 5'd16, 1'b0, 9'h050);
    expect_miss(7);
    except = 1'b1;
    tick();
    except = 1'b0;
    refill(7);
    repeat (3) begin
      if (op_en || fault) begin
        $display("Fail %0t ns: operation dropped by except still resolved", $time);
        errors++;
      end
      tick();
    end
    a = page_addr(0, 6'd3, 7'h00);
    send_op(a, 5'd17, 1'b0, 9'h051);
    compare_issue(a, 5'd17, 1'b0, 9'h051);
    tlb_flush = 1'b1;
    tick();
    tlb_flush = 1'b0;
    send_op(a, 5'd17, 1'b0, 9'h052);
    expect_miss(0);
    except = 1'b1;
    tick();
    except = 1'b0;
    report_test("except and flush", e0);
  endtask

  initial begin
    rst = 1'b1;
    in_en = 1'b0;
    in_addr = '0;
    in_sz = '0;
    in_st = 1'b0;
    in_tag = '0;
    except = 1'b0;
    user_mode = 1'b0;
    tlb_wen = 1'b0;
    tlb_vpn = '0;
    tlb_ppn = '0;
    tlb_sys = 1'b0;
    tlb_na = 1'b0;
    tlb_flush = 1'b0;
    for (int k = 0; k < 9; k++) begin
      ppn_tab[k] = agu_pkg::ppn_t'(32'h0002_b000 + 32'(k) * 32'h111);
      sys_tab[k] = 1'b0;
      na_tab[k] = 1'b0;
    end
    na_tab[3] = 1'b1;
    sys_tab[4] = 1'b1;
    na_tab[6] = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_state();
    miss_and_refill();
    bank_spans();
    page_crossing();
    permission_faults();
    except_and_flush();
    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/agu_pkg.sv
verilog/tlb_lookup_if.sv
verilog/dtlb.sv
verilog/bank_mask.sv
verilog/agu_stage.sv
verilog/agu_top.sv
bench/agu_tb.sv

//--- Bender.yml
package:
  name: agu

sources:
  - verilog/agu_pkg.sv
  - verilog/tlb_lookup_if.sv
  - verilog/dtlb.sv
  - verilog/bank_mask.sv
  - verilog/agu_stage.sv
  - verilog/agu_top.sv
  - target: test
    files:
      - bench/agu_tb.sv
